//--- hw/flow_pkg.sv
// Flow lookup definitions
// Key, mask and action types plus table sizes shared by both flow tables
package flow_pkg;

   // Key layout is ingress port followed by IPv4 destination
   localparam int PORT_W = 8;
   localparam int IPV4_W = 32;
   localparam int KEY_W  = PORT_W + IPV4_W;

   // Output port bitmap, top bit is the controller port
   localparam int ACTION_W  = 8;
   localparam int CTRL_PORT = 7;

   localparam int EXACT_DEPTH = 8;
   localparam int WILD_DEPTH  = 4;

   typedef logic [KEY_W-1:0] flow_key_t;

   // 1 = compare this key bit
   typedef logic [KEY_W-1:0] flow_mask_t;

   typedef logic [ACTION_W-1:0] flow_action_t;

   typedef logic [$clog2(EXACT_DEPTH)-1:0] exact_addr_t;
   typedef logic [$clog2(WILD_DEPTH)-1:0]  wild_addr_t;

   // Unmatched flows go to the controller only
   localparam flow_action_t MISS_ACTION = flow_action_t'(1) << CTRL_PORT;

endpackage

//--- hw/host_pkg.sv
// Host side definitions
// Table select, write index and statistics counter types
package host_pkg;

   localparam int STAT_W     = 32;
   localparam int TBL_ADDR_W = 3;

   // Which flow table a host write targets
   typedef logic tbl_sel_t;

   localparam tbl_sel_t TBL_EXACT = 1'b0;
   localparam tbl_sel_t TBL_WILD  = 1'b1;

   // Wide enough for the larger table
   typedef logic [TBL_ADDR_W-1:0] tbl_addr_t;

   // Free running, wraps on overflow
   typedef logic [STAT_W-1:0] stat_cnt_t;

endpackage

//--- hw/exact_match_tbl.sv
// Exact match flow table
// Full key compare against all entries, lowest index wins, result one cycle later
`timescale 1ns/1ps

module exact_match_tbl (
   input  logic                  asclk,
   input  logic                  rst,
   input  logic                  wr,
   input  flow_pkg::exact_addr_t addr,
   input  flow_pkg::flow_key_t   match,
   input  flow_pkg::flow_action_t action,
   input  logic                  valid,
   input  logic                  lu_req,
   input  flow_pkg::flow_key_t   lu_key,
   output logic                  hit_valid,
   output logic                  hit,
   output flow_pkg::flow_action_t hit_action
);

   logic [flow_pkg::EXACT_DEPTH-1:0] ent_valid;
   flow_pkg::flow_key_t              ent_key    [flow_pkg::EXACT_DEPTH];
   flow_pkg::flow_action_t           ent_action [flow_pkg::EXACT_DEPTH];

   logic                   cmp_hit;
   flow_pkg::flow_action_t cmp_action;

   // Entry valid bits
   always_ff @(posedge asclk) begin
      if (rst) begin
         ent_valid <= '0;
      end else if (wr) begin
         ent_valid[addr] <= valid;
      end
   end

   // Entry contents
   always_ff @(posedge asclk) begin
      if (wr) begin
         ent_key[addr]    <= match;
         ent_action[addr] <= action;
      end
   end

   // Walk downwards so the lowest matching index is assigned last
   always_comb begin
      cmp_hit    = 1'b0;
      cmp_action = flow_pkg::MISS_ACTION;
      for (int i = flow_pkg::EXACT_DEPTH - 1; i >= 0; i--) begin
         if (ent_valid[i] && (ent_key[i] == lu_key)) begin
            cmp_hit    = 1'b1;
            cmp_action = ent_action[i];
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (rst) begin
         hit_valid <= 1'b0;
         hit       <= 1'b0;
      end else begin
         hit_valid <= lu_req;
         hit       <= lu_req && cmp_hit;
      end
   end

   always_ff @(posedge asclk) begin
      if (lu_req) begin
         hit_action <= cmp_action;
      end
   end

endmodule

//--- hw/wildcard_match_tbl.sv
// Wildcard flow table
// Masked key compare per entry, lowest index wins, result one cycle later
`timescale 1ns/1ps

module wildcard_match_tbl (
   input  logic                   asclk,
   input  logic                   rst,
   input  logic                   wr,
   input  flow_pkg::wild_addr_t   addr,
   input  flow_pkg::flow_key_t    match,
   input  flow_pkg::flow_mask_t   mask,
   input  flow_pkg::flow_action_t action,
   input  logic                   valid,
   input  logic                   lu_req,
   input  flow_pkg::flow_key_t    lu_key,
   output logic                   hit_valid,
   output logic                   hit,
   output flow_pkg::flow_action_t hit_action
);

   logic [flow_pkg::WILD_DEPTH-1:0] ent_valid;
   flow_pkg::flow_key_t             ent_key    [flow_pkg::WILD_DEPTH];
   flow_pkg::flow_mask_t            ent_mask   [flow_pkg::WILD_DEPTH];
   flow_pkg::flow_action_t          ent_action [flow_pkg::WILD_DEPTH];

   logic [flow_pkg::WILD_DEPTH-1:0] ent_match;
   logic                            cmp_hit;
   flow_pkg::flow_action_t          cmp_action;

   always_ff @(posedge asclk) begin
      if (rst) begin
         ent_valid <= '0;
      end else if (wr) begin
         ent_valid[addr] <= valid;
      end
   end

   // Key stored pre-masked so the compare needs only one AND
   always_ff @(posedge asclk) begin
      if (wr) begin
         ent_key[addr]    <= match & mask;
         ent_mask[addr]   <= mask;
         ent_action[addr] <= action;
      end
   end

   // Per entry match vector
   always_comb begin
      for (int i = 0; i < flow_pkg::WILD_DEPTH; i++) begin
         ent_match[i] = ent_valid[i] && ((lu_key & ent_mask[i]) == ent_key[i]);
      end
   end

   // Priority select, lowest index wins
   always_comb begin
      cmp_hit    = 1'b0;
      cmp_action = flow_pkg::MISS_ACTION;
      for (int i = flow_pkg::WILD_DEPTH - 1; i >= 0; i--) begin
         if (ent_match[i]) begin
            cmp_hit    = 1'b1;
            cmp_action = ent_action[i];
         end
      end
   end

   always_ff @(posedge asclk) begin
      if (rst) begin
         hit_valid <= 1'b0;
         hit       <= 1'b0;
      end else begin
         hit_valid <= lu_req;
         hit       <= lu_req && cmp_hit;
      end
   end

   always_ff @(posedge asclk) begin
      if (lu_req) begin
         hit_action <= cmp_action;
      end
   end

endmodule

//--- hw/action_resolve.sv
// Lookup result resolver
// Exact hit over wildcard hit over miss, plus hit and miss statistics
`timescale 1ns/1ps

module action_resolve (
   input  logic                   asclk,
   input  logic                   rst,
   input  logic                   ex_valid,
   input  logic                   ex_hit,
   input  flow_pkg::flow_action_t ex_action,
   input  logic                   wc_hit,
   input  flow_pkg::flow_action_t wc_action,
   output logic                   lu_done,
   output logic                   lu_exact_hit,
   output logic                   lu_wild_hit,
   output flow_pkg::flow_action_t lu_action,
   output host_pkg::stat_cnt_t    exact_hit,
   output host_pkg::stat_cnt_t    exact_miss,
   output host_pkg::stat_cnt_t    wildcard_hit,
   output host_pkg::stat_cnt_t    wildcard_miss
);

   flow_pkg::flow_action_t sel_action;

   // Both tables answer on the same cycle, so ex_valid times the pair
   always_comb begin
      if (ex_hit) begin
         sel_action = ex_action;
      end else if (wc_hit) begin
         sel_action = wc_action;
      end else begin
         sel_action = flow_pkg::MISS_ACTION;
      end
   end

   always_ff @(posedge asclk) begin
      if (rst) begin
         lu_done      <= 1'b0;
         lu_exact_hit <= 1'b0;
         lu_wild_hit  <= 1'b0;
      end else begin
         lu_done      <= ex_valid;
         lu_exact_hit <= ex_valid && ex_hit;
         lu_wild_hit  <= ex_valid && !ex_hit && wc_hit;
      end
   end

   always_ff @(posedge asclk) begin
      if (ex_valid) begin
         lu_action <= sel_action;
      end
   end

   // Wildcard counters only move when the exact table missed
   always_ff @(posedge asclk) begin
      if (rst) begin
         exact_hit     <= '0;
         exact_miss    <= '0;
         wildcard_hit  <= '0;
         wildcard_miss <= '0;
      end else if (ex_valid) begin
         if (ex_hit) begin
            exact_hit <= exact_hit + 1'b1;
         end else begin
            exact_miss <= exact_miss + 1'b1;
            if (wc_hit) begin
               wildcard_hit <= wildcard_hit + 1'b1;
            end else begin
               wildcard_miss <= wildcard_miss + 1'b1;
            end
         end
      end
   end

endmodule

//--- hw/flow_lookup.sv
// Flow lookup top level
// Host write decode, exact and wildcard tables searched in parallel, result resolve
`timescale 1ns/1ps

module flow_lookup (
   input  logic                   asclk,
   input  logic                   rst,
   input  logic                   tbl_wr,
   input  host_pkg::tbl_sel_t     tbl_sel,
   input  host_pkg::tbl_addr_t    tbl_addr,
   input  flow_pkg::flow_key_t    tbl_match,
   input  flow_pkg::flow_mask_t   tbl_mask,
   input  flow_pkg::flow_action_t tbl_action,
   input  logic                   tbl_valid,
   input  logic                   lu_req,
   input  flow_pkg::flow_key_t    lu_key,
   output logic                   lu_done,
   output logic                   lu_exact_hit,
   output logic                   lu_wild_hit,
   output flow_pkg::flow_action_t lu_action,
   output host_pkg::stat_cnt_t    exact_hit,
   output host_pkg::stat_cnt_t    exact_miss,
   output host_pkg::stat_cnt_t    wildcard_hit,
   output host_pkg::stat_cnt_t    wildcard_miss
);

   logic                   exact_wr;
   logic                   wild_wr;
   logic                   ex_valid;
   logic                   ex_hit;
   flow_pkg::flow_action_t ex_action;
   logic                   wc_hit;
   flow_pkg::flow_action_t wc_action;

   // Steer the host strobe to one table
   assign exact_wr = tbl_wr && (tbl_sel == host_pkg::TBL_EXACT);
   assign wild_wr  = tbl_wr && (tbl_sel == host_pkg::TBL_WILD);

   exact_match_tbl u_exact (
      .asclk      (asclk),
      .rst        (rst),
      .wr         (exact_wr),
      .addr       (tbl_addr),
      .match      (tbl_match),
      .action     (tbl_action),
      .valid      (tbl_valid),
      .lu_req     (lu_req),
      .lu_key     (lu_key),
      .hit_valid  (ex_valid),
      .hit        (ex_hit),
      .hit_action (ex_action)
   );

   // Same latency as the exact table, its valid is not needed
   wildcard_match_tbl u_wild (
      .asclk      (asclk),
      .rst        (rst),
      .wr         (wild_wr),
      .addr       (tbl_addr[1:0]),
      .match      (tbl_match),
      .mask       (tbl_mask),
      .action     (tbl_action),
      .valid      (tbl_valid),
      .lu_req     (lu_req),
      .lu_key     (lu_key),
      .hit_valid  (),
      .hit        (wc_hit),
      .hit_action (wc_action)
   );

   action_resolve u_resolve (
      .asclk         (asclk),
      .rst           (rst),
      .ex_valid      (ex_valid),
      .ex_hit        (ex_hit),
      .ex_action     (ex_action),
      .wc_hit        (wc_hit),
      .wc_action     (wc_action),
      .lu_done       (lu_done),
      .lu_exact_hit  (lu_exact_hit),
      .lu_wild_hit   (lu_wild_hit),
      .lu_action     (lu_action),
      .exact_hit     (exact_hit),
      .exact_miss    (exact_miss),
      .wildcard_hit  (wildcard_hit),
      .wildcard_miss (wildcard_miss)
   );

endmodule

//--- test/flow_lookup_assertions.sv
// Flow lookup assertions
// Result timing and hit flag consistency, bound into the top level
`timescale 1ns/1ps

module flow_lookup_assertions (
   input logic asclk,
   input logic rst,
   input logic lu_req,
   input logic lu_done,
   input logic lu_exact_hit,
   input logic lu_wild_hit
);

   int fail_count = 0;

   // Every request answered two cycles later
   a_done_after_req: assert property (@(posedge asclk) disable iff (rst)
      lu_req |-> ##2 lu_done)
      else begin
         $error("lu_done did not follow lu_req after 2 cycles");
         fail_count++;
      end

   // No result without a request two cycles earlier
   a_done_has_req: assert property (@(posedge asclk) disable iff (rst)
      lu_done |-> $past(lu_req, 2))
      else begin
         $error("lu_done without lu_req 2 cycles earlier");
         fail_count++;
      end

   a_hit_exclusive: assert property (@(posedge asclk) disable iff (rst)
      !(lu_exact_hit && lu_wild_hit))
      else begin
         $error("lu_exact_hit and lu_wild_hit both high");
         fail_count++;
      end

   a_hit_quiet: assert property (@(posedge asclk) disable iff (rst)
      !lu_done |-> (!lu_exact_hit && !lu_wild_hit))
      else begin
         $error("hit flag high while lu_done is low");
         fail_count++;
      end

endmodule

bind flow_lookup flow_lookup_assertions u_assert (
   .asclk        (asclk),
   .rst          (rst),
   .lu_req       (lu_req),
   .lu_done      (lu_done),
   .lu_exact_hit (lu_exact_hit),
   .lu_wild_hit  (lu_wild_hit)
);

//--- test/flow_lookup_tb.sv
// Flow lookup testbench
// Table-driven writes and lookups, then back-to-back LFSR lookups against a table model
`timescale 1ns/1ps

module flow_lookup_tb;

   localparam int CLK_PERIOD  = 20;
   localparam int N_ROWS      = 16;
   localparam int N_RAND      = 32;
   localparam int WATCHDOG_NS = (N_ROWS + N_RAND + 20) * CLK_PERIOD;

   // Controller port only
   localparam flow_pkg::flow_action_t EXP_MISS = 8'h80;

   localparam flow_pkg::flow_key_t KEY_A = 40'h01_0A00_0001;
   localparam flow_pkg::flow_key_t KEY_B = 40'h02_C0A8_0005;
   localparam flow_pkg::flow_key_t KEY_W = 40'h05_0A00_0001;

   // For lookup rows, action holds the expected action
   typedef struct {
      logic                   is_wr;
      host_pkg::tbl_sel_t     sel;
      host_pkg::tbl_addr_t    addr;
      flow_pkg::flow_key_t    key;
      flow_pkg::flow_mask_t   mask;
      flow_pkg::flow_action_t action;
      logic                   valid;
      logic                   exp_ex;
      logic                   exp_wc;
   } row_t;

   logic                   asclk = 1'b0;
   logic                   rst;
   logic                   tbl_wr;
   host_pkg::tbl_sel_t     tbl_sel;
   host_pkg::tbl_addr_t    tbl_addr;
   flow_pkg::flow_key_t    tbl_match;
   flow_pkg::flow_mask_t   tbl_mask;
   flow_pkg::flow_action_t tbl_action;
   logic                   tbl_valid;
   logic                   lu_req;
   flow_pkg::flow_key_t    lu_key;
   logic                   lu_done;
   logic                   lu_exact_hit;
   logic                   lu_wild_hit;
   flow_pkg::flow_action_t lu_action;
   host_pkg::stat_cnt_t    exact_hit;
   host_pkg::stat_cnt_t    exact_miss;
   host_pkg::stat_cnt_t    wildcard_hit;
   host_pkg::stat_cnt_t    wildcard_miss;

   row_t rows [N_ROWS];
   int   n_fill = 0;
   int   n_checks = 0;
   int   n_errors = 0;
   int   cyc = 0;
   logic [39:0] lfsr;

   // Reference model of both tables
   logic                   m_ex_valid [flow_pkg::EXACT_DEPTH];
   flow_pkg::flow_key_t    m_ex_key   [flow_pkg::EXACT_DEPTH];
   flow_pkg::flow_action_t m_ex_act   [flow_pkg::EXACT_DEPTH];
   logic                   m_wc_valid [flow_pkg::WILD_DEPTH];
   flow_pkg::flow_key_t    m_wc_key   [flow_pkg::WILD_DEPTH];
   flow_pkg::flow_mask_t   m_wc_mask  [flow_pkg::WILD_DEPTH];
   flow_pkg::flow_action_t m_wc_act   [flow_pkg::WILD_DEPTH];

   host_pkg::stat_cnt_t cnt_ex_hit = '0;
   host_pkg::stat_cnt_t cnt_ex_miss = '0;
   host_pkg::stat_cnt_t cnt_wc_hit = '0;
   host_pkg::stat_cnt_t cnt_wc_miss = '0;

   // Results still in flight during the random phase
   flow_pkg::flow_key_t    q_key [$];
   flow_pkg::flow_action_t q_act [$];
   logic                   q_ex  [$];
   logic                   q_wc  [$];
   int                     q_cyc [$];

   flow_lookup u_dut (
      .asclk         (asclk),
      .rst           (rst),
      .tbl_wr        (tbl_wr),
      .tbl_sel       (tbl_sel),
      .tbl_addr      (tbl_addr),
      .tbl_match     (tbl_match),
      .tbl_mask      (tbl_mask),
      .tbl_action    (tbl_action),
      .tbl_valid     (tbl_valid),
      .lu_req        (lu_req),
      .lu_key        (lu_key),
      .lu_done       (lu_done),
      .lu_exact_hit  (lu_exact_hit),
      .lu_wild_hit   (lu_wild_hit),
      .lu_action     (lu_action),
      .exact_hit     (exact_hit),
      .exact_miss    (exact_miss),
      .wildcard_hit  (wildcard_hit),
      .wildcard_miss (wildcard_miss)
   );

   always #(CLK_PERIOD / 2) asclk = ~asclk;

   always @(posedge asclk) begin
      cyc <= cyc + 1;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
      $display("Done: errors found");
      $finish;
   end

   function automatic logic [39:0] lfsr_next(input logic [39:0] s);
      logic fb;
      // Taps 40, 38, 21, 19
      fb = s[39] ^ s[37] ^ s[20] ^ s[18];
      return {s[38:0], fb};
   endfunction

   task automatic take_bits(input int n, output logic [39:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val  = {val[38:0], lfsr[39]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic check_action(input string name, input flow_pkg::flow_action_t got,
                               input flow_pkg::flow_action_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input host_pkg::stat_cnt_t got,
                              input host_pkg::stat_cnt_t exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic add_write(input host_pkg::tbl_sel_t sel, input host_pkg::tbl_addr_t addr,
                            input flow_pkg::flow_key_t key, input flow_pkg::flow_mask_t mask,
                            input flow_pkg::flow_action_t action, input logic valid);
      rows[n_fill] = '{1'b1, sel, addr, key, mask, action, valid, 1'b0, 1'b0};
      n_fill++;
   endtask

   task automatic add_lookup(input flow_pkg::flow_key_t key, input flow_pkg::flow_action_t act,
                             input logic exp_ex, input logic exp_wc);
      rows[n_fill] = '{1'b0, host_pkg::TBL_EXACT, '0, key, '0, act, 1'b0, exp_ex, exp_wc};
      n_fill++;
   endtask

   task automatic fill_table();
      add_lookup(KEY_A, EXP_MISS, 1'b0, 1'b0);
      add_lookup(40'h0, EXP_MISS, 1'b0, 1'b0);
      add_write(host_pkg::TBL_EXACT, 3'd2, KEY_A, '0, 8'h03, 1'b1);
      add_lookup(KEY_A, 8'h03, 1'b1, 1'b0);
      add_lookup(KEY_A ^ 40'h1, EXP_MISS, 1'b0, 1'b0);
      // Address 5 lands on wildcard entry 1
      add_write(host_pkg::TBL_WILD, 3'd5, 40'h05_0A00_0000, 40'hFF_FF00_0000, 8'h10, 1'b1);
      add_write(host_pkg::TBL_WILD, 3'd2, 40'h05_0000_0000, 40'hFF_0000_0000, 8'h20, 1'b1);
      add_lookup(40'h05_0A0B_0C0D, 8'h10, 1'b0, 1'b1);
      add_lookup(40'h05_0B00_0000, 8'h20, 1'b0, 1'b1);
      add_lookup(40'h06_0A00_0000, EXP_MISS, 1'b0, 1'b0);
      add_write(host_pkg::TBL_EXACT, 3'd5, KEY_W, '0, 8'h41, 1'b1);
      add_lookup(KEY_W, 8'h41, 1'b1, 1'b0);
      add_write(host_pkg::TBL_EXACT, 3'd5, KEY_W, '0, 8'h41, 1'b0);
      add_lookup(KEY_W, 8'h10, 1'b0, 1'b1);
      add_write(host_pkg::TBL_EXACT, 3'd0, KEY_B, '0, 8'h0C, 1'b1);
      add_lookup(KEY_B, 8'h0C, 1'b1, 1'b0);
   endtask

   task automatic model_write(input row_t r);
      if (r.sel == host_pkg::TBL_EXACT) begin
         m_ex_valid[r.addr] = r.valid;
         m_ex_key[r.addr]   = r.key;
         m_ex_act[r.addr]   = r.action;
      end else begin
         m_wc_valid[r.addr[1:0]] = r.valid;
         m_wc_key[r.addr[1:0]]   = r.key;
         m_wc_mask[r.addr[1:0]]  = r.mask;
         m_wc_act[r.addr[1:0]]   = r.action;
      end
   endtask

   // Exact hit overrides wildcard and the lowest matching index wins in each table
   task automatic predict(input flow_pkg::flow_key_t key, output flow_pkg::flow_action_t act,
                          output logic ex, output logic wc);
      ex  = 1'b0;
      wc  = 1'b0;
      act = EXP_MISS;
      for (int i = 0; i < flow_pkg::WILD_DEPTH; i++) begin
         if (!wc && m_wc_valid[i] && (((key ^ m_wc_key[i]) & m_wc_mask[i]) == '0)) begin
            wc  = 1'b1;
            act = m_wc_act[i];
         end
      end
      for (int i = 0; i < flow_pkg::EXACT_DEPTH; i++) begin
         if (!ex && m_ex_valid[i] && (key == m_ex_key[i])) begin
            ex  = 1'b1;
            act = m_ex_act[i];
         end
      end
      if (ex) begin
         wc = 1'b0;
      end
   endtask

   task automatic count_expected(input logic ex, input logic wc);
      if (ex) begin
         cnt_ex_hit++;
      end else begin
         cnt_ex_miss++;
         if (wc) begin
            cnt_wc_hit++;
         end else begin
            cnt_wc_miss++;
         end
      end
   endtask

   task automatic check_result(input flow_pkg::flow_action_t act, input logic ex,
                               input logic wc);
      check_action("lu_action", lu_action, act);
      check_flag("lu_exact_hit", lu_exact_hit, ex);
      check_flag("lu_wild_hit", lu_wild_hit, wc);
   endtask

   task automatic check_counters(input string name);
      int errs_before;
      errs_before = n_errors;
      check_count("exact_hit", exact_hit, cnt_ex_hit);
      check_count("exact_miss", exact_miss, cnt_ex_miss);
      check_count("wildcard_hit", wildcard_hit, cnt_wc_hit);
      check_count("wildcard_miss", wildcard_miss, cnt_wc_miss);
      $display("Counters %s: %s", name, (n_errors == errs_before) ? "ok" : "FAILED");
   endtask

   task automatic apply_row(input int r);
      int errs_before;
      int wait_cyc;
      errs_before = n_errors;
      if (rows[r].is_wr) begin
         tbl_wr     = 1'b1;
         tbl_sel    = rows[r].sel;
         tbl_addr   = rows[r].addr;
         tbl_match  = rows[r].key;
         tbl_mask   = rows[r].mask;
         tbl_action = rows[r].action;
         tbl_valid  = rows[r].valid;
         @(negedge asclk);
         tbl_wr = 1'b0;
         model_write(rows[r]);
      end else begin
         lu_req = 1'b1;
         lu_key = rows[r].key;
         @(negedge asclk);
         lu_req   = 1'b0;
         wait_cyc = 1;
         while (!lu_done && wait_cyc < 4) begin
            @(negedge asclk);
            wait_cyc++;
         end
         count_expected(rows[r].exp_ex, rows[r].exp_wc);
         if (!lu_done) begin
            n_errors++;
            $display("Row %0d: lu_done did not rise within 4 cycles of lu_req", r);
         end else begin
            check_result(rows[r].action, rows[r].exp_ex, rows[r].exp_wc);
         end
         $display("Row %0d lookup %h: %s", r, rows[r].key,
                  (n_errors == errs_before) ? "ok" : "FAILED");
      end
   endtask

   task automatic run_random();
      logic [39:0]            bits;
      logic [39:0]            raw;
      flow_pkg::flow_key_t    key;
      flow_pkg::flow_action_t act;
      logic                   ex;
      logic                   wc;
      flow_pkg::flow_key_t    got_key;
      flow_pkg::flow_action_t exp_act;
      logic                   exp_ex;
      logic                   exp_wc;
      int                     got;
      int                     errs_before;
      int                     lat;
      fork
         begin
            for (int k = 0; k < N_RAND; k++) begin
               take_bits(2, bits);
               take_bits(40, raw);
               // Mix of random keys, wildcard port 5 keys and stored exact keys
               case (bits[1:0])
                  2'd0:    key = raw;
                  2'd1:    key = {8'h05, raw[31:0]};
                  default: key = m_ex_key[raw[2:0]];
               endcase
               predict(key, act, ex, wc);
               q_key.push_back(key);
               q_act.push_back(act);
               q_ex.push_back(ex);
               q_wc.push_back(wc);
               q_cyc.push_back(cyc);
               lu_req = 1'b1;
               lu_key = key;
               @(negedge asclk);
            end
            lu_req = 1'b0;
         end
         begin
            got = 0;
            while (got < N_RAND) begin
               @(negedge asclk);
               if (lu_done) begin
                  errs_before = n_errors;
                  got_key = q_key.pop_front();
                  exp_act = q_act.pop_front();
                  exp_ex  = q_ex.pop_front();
                  exp_wc  = q_wc.pop_front();
                  lat     = cyc - q_cyc.pop_front();
                  count_expected(exp_ex, exp_wc);
                  check_result(exp_act, exp_ex, exp_wc);
                  if (lat != 2) begin
                     n_errors++;
                     $display("Random %0d: result came %0d cycles after lu_req, not 2", got, lat);
                  end
                  $display("Random %0d key %h: %s", got, got_key,
                           (n_errors == errs_before) ? "ok" : "FAILED");
                  got++;
               end
            end
         end
      join
   endtask

   initial begin
      rst        = 1'b1;
      tbl_wr     = 1'b0;
      tbl_sel    = host_pkg::TBL_EXACT;
      tbl_addr   = '0;
      tbl_match  = '0;
      tbl_mask   = '0;
      tbl_action = '0;
      tbl_valid  = 1'b0;
      lu_req     = 1'b0;
      lu_key     = '0;
      lfsr       = 40'd70;
      for (int i = 0; i < flow_pkg::EXACT_DEPTH; i++) begin
         m_ex_valid[i] = 1'b0;
         m_ex_key[i]   = '0;
         m_ex_act[i]   = '0;
      end
      for (int i = 0; i < flow_pkg::WILD_DEPTH; i++) begin
         m_wc_valid[i] = 1'b0;
         m_wc_key[i]   = '0;
         m_wc_mask[i]  = '0;
         m_wc_act[i]   = '0;
      end
      fill_table();

      repeat (2) @(posedge asclk);
      @(negedge asclk);
      rst = 1'b0;
      check_counters("after reset");

      for (int r = 0; r < N_ROWS; r++) begin
         apply_row(r);
      end
      run_random();
      @(negedge asclk);
      check_counters("at end");

      n_errors = n_errors + u_dut.u_assert.fail_count;
      $display("Summary: %0d checks, %0d errors, %0d assertion failures",
               n_checks, n_errors, u_dut.u_assert.fail_count);
      if (n_errors == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

endmodule

//--- flow_lookup.f
hw/flow_pkg.sv
hw/host_pkg.sv
hw/exact_match_tbl.sv
hw/wildcard_match_tbl.sv
hw/action_resolve.sv
hw/flow_lookup.sv
test/flow_lookup_assertions.sv
test/flow_lookup_tb.sv

//--- Bender.yml
package:
  name: flow_lookup

sources:
  - files:
      - hw/flow_pkg.sv
      - hw/host_pkg.sv
      - hw/exact_match_tbl.sv
      - hw/wildcard_match_tbl.sv
      - hw/action_resolve.sv
      - hw/flow_lookup.sv
  - target: test
    files:
      - test/flow_lookup_assertions.sv
      - test/flow_lookup_tb.sv
